// ==== Makefile ====
TOP = tbAudioTxUnit

.PHONY: all lint clean

# Build, run, and decide on the log contents
all:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) -Mdir obj_dir -o simAudio
	./obj_dir/simAudio > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module audioTxUnit

clean:
	rm -rf obj_dir sim.log

// ==== hw/audioPkg.sv ====
`default_nettype none
`include "audio_defs.svh"

package audioPkg;

	// --------------------------------------------------
	// Duty source select
	// --------------------------------------------------
	typedef enum logic [1:0]
	{
		MODE_DIRECT = 2'd0,
		MODE_TONE   = 2'd1,
		MODE_PCM    = 2'd2
	} audioMode_t;

	// --------------------------------------------------
	// Sample memory port
	// --------------------------------------------------
	// Request word, write set for host traffic only
	typedef struct packed
	{
		logic                       valid;
		logic                       write;
		logic [`AUDIO_MEM_AW-1:0]   adrs;
		logic [`AUDIO_SAMPLE_W-1:0] data;
	} memReq_t;

	// Read response, one clock after the grant
	typedef struct packed
	{
		logic                       valid;
		logic [`AUDIO_SAMPLE_W-1:0] data;
	} memRsp_t;

	// --------------------------------------------------
	// Note table
	// --------------------------------------------------
	// Phase steps for the lowest octave, tones 0 to 11
	// Higher octaves shift these left by the octave number
	localparam logic [`AUDIO_PHASE_W-1:0] NOTE_STEP [12] =
		'{16'd64, 16'd68, 16'd72, 16'd76, 16'd81, 16'd86,
		  16'd91, 16'd96, 16'd102, 16'd108, 16'd114, 16'd121};

endpackage

`default_nettype wire

// ==== hw/audioTxUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module audioTxUnit
(
	input  logic                       audioClk,
	input  logic                       rstN,
	input  logic                       audioCke,
	input  audioPkg::audioMode_t       audioMode,
	input  logic [6:0]                 audioTone,
	input  logic [`AUDIO_SAMPLE_W-1:0] audioDuty,
	input  audioPkg::memReq_t          hostWr,
	input  logic [`AUDIO_MEM_AW-1:0]   dmaAdrs,
	input  logic [`AUDIO_MEM_AW-1:0]   dmaLen,
	input  logic                       dmaEn,
	output logic                       audioPwm,
	output logic                       frameSync,
	output logic                       dmaBusy
);

	logic [`AUDIO_SAMPLE_W-1:0] waveIndex;
	logic [`AUDIO_SAMPLE_W-1:0] toneSample;
	logic [`AUDIO_SAMPLE_W-1:0] pcmSample;
	audioPkg::memReq_t          dmaReq;
	logic                       dmaGnt;
	audioPkg::memRsp_t          dmaRsp;

	// --------------------------------------------------
	// Tone source
	// --------------------------------------------------
	toneStepper toneStepper_inst
	(
		.audioClk   (audioClk),
		.rstN       (rstN),
		.frameSync  (frameSync),
		.audioTone  (audioTone),
		.waveIndex  (waveIndex)
	);

	waveTableRom waveTableRom_inst
	(
		.audioClk   (audioClk),
		.waveIndex  (waveIndex),
		.toneSample (toneSample)
	);

	// --------------------------------------------------
	// PCM source
	// --------------------------------------------------
	pcmDmaReader pcmDmaReader_inst
	(
		.audioClk   (audioClk),
		.rstN       (rstN),
		.frameSync  (frameSync),
		.dmaAdrs    (dmaAdrs),
		.dmaLen     (dmaLen),
		.dmaEn      (dmaEn),
		.dmaReq     (dmaReq),
		.dmaGnt     (dmaGnt),
		.dmaRsp     (dmaRsp),
		.pcmSample  (pcmSample),
		.dmaBusy    (dmaBusy)
	);

	// Host writes and DMA reads share the sample memory
	sampleMemArbiter sampleMemArbiter_inst
	(
		.audioClk   (audioClk),
		.rstN       (rstN),
		.hostWr     (hostWr),
		.dmaReq     (dmaReq),
		.dmaGnt     (dmaGnt),
		.dmaRsp     (dmaRsp)
	);

	// --------------------------------------------------
	// PWM output
	// --------------------------------------------------
	pwmDutyGen pwmDutyGen_inst
	(
		.audioClk   (audioClk),
		.rstN       (rstN),
		.audioCke   (audioCke),
		.audioMode  (audioMode),
		.audioDuty  (audioDuty),
		.toneSample (toneSample),
		.pcmSample  (pcmSample),
		.frameSync  (frameSync),
		.audioPwm   (audioPwm)
	);

endmodule

`default_nettype wire

// ==== hw/audio_defs.svh ====
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// Sample level and PWM duty width
`define AUDIO_SAMPLE_W 8

// Sample memory address width, 1024 words
`define AUDIO_MEM_AW 10

// Tone phase accumulator width
// Top AUDIO_SAMPLE_W bits index the wave table
`define AUDIO_PHASE_W 16

// Clocks per PWM frame, power of two
`define AUDIO_FRAME_LEN 256

// Highest legal tone number
// Anything above plays this tone
`define AUDIO_TONE_MAX 95

`endif

// ==== hw/pcmDmaReader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module pcmDmaReader
(
	input  logic                       audioClk,
	input  logic                       rstN,
	input  logic                       frameSync,
	input  logic [`AUDIO_MEM_AW-1:0]   dmaAdrs,
	input  logic [`AUDIO_MEM_AW-1:0]   dmaLen,
	input  logic                       dmaEn,
	output audioPkg::memReq_t          dmaReq,
	input  logic                       dmaGnt,
	input  audioPkg::memRsp_t          dmaRsp,
	output logic [`AUDIO_SAMPLE_W-1:0] pcmSample,
	output logic                       dmaBusy
);

	logic                     dmaEnQ;
	logic                     dmaStart;
	logic                     reqIssue;
	logic                     reqValid;
	logic [`AUDIO_MEM_AW-1:0] reqAdrs;
	logic [`AUDIO_MEM_AW-1:0] curAdrs;
	logic [`AUDIO_MEM_AW-1:0] remain;

	// Rising edge of the enable level starts a transfer
	assign dmaStart = dmaEn && !dmaEnQ;
	// One fetch per frame while words are left
	assign reqIssue = frameSync && dmaBusy && !reqValid && (remain != '0);

	// --------------------------------------------------
	// Transfer control
	// --------------------------------------------------
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
		begin
			dmaEnQ   <= 1'b0;
			dmaBusy  <= 1'b0;
			reqValid <= 1'b0;
			reqAdrs  <= '0;
			curAdrs  <= '0;
			remain   <= '0;
		end
		else
		begin
			dmaEnQ <= dmaEn;
			// Request stays up until the arbiter takes it
			if (reqIssue)
			begin
				reqValid <= 1'b1;
				reqAdrs  <= curAdrs;
				// Address wraps at the memory size
				curAdrs  <= curAdrs + 1'b1;
				remain   <= remain - 1'b1;
			end
			else if (dmaGnt)
				reqValid <= 1'b0;
			// Busy drops once the last word has landed
			if (dmaRsp.valid && (remain == '0))
				dmaBusy <= 1'b0;
			// A new start overrides the running counters
			if (dmaStart)
			begin
				curAdrs <= dmaAdrs;
				remain  <= dmaLen;
				dmaBusy <= (dmaLen != '0);
			end
		end
	end

	// Last fetched word, held after the transfer ends
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			pcmSample <= '0;
		else if (dmaRsp.valid)
			pcmSample <= dmaRsp.data;
	end

	// Reads only
	assign dmaReq = '{valid: reqValid, write: 1'b0, adrs: reqAdrs, data: '0};

	// Pending request must not move before the grant
	reqHeldUntilGrant : assert property (@(posedge audioClk) disable iff (!rstN)
		(dmaReq.valid && !dmaGnt) |=> (dmaReq.valid && $stable(dmaReq.adrs)))
		else $error("DMA request dropped or changed before grant");

endmodule

`default_nettype wire

// ==== hw/pwmDutyGen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module pwmDutyGen
(
	input  logic                       audioClk,
	input  logic                       rstN,
	input  logic                       audioCke,
	input  audioPkg::audioMode_t       audioMode,
	input  logic [`AUDIO_SAMPLE_W-1:0] audioDuty,
	input  logic [`AUDIO_SAMPLE_W-1:0] toneSample,
	input  logic [`AUDIO_SAMPLE_W-1:0] pcmSample,
	output logic                       frameSync,
	output logic                       audioPwm
);

	localparam int CntW = $clog2(`AUDIO_FRAME_LEN);
	localparam logic [CntW-1:0] CntLast = CntW'(`AUDIO_FRAME_LEN - 1);

	logic [CntW-1:0]            frameCnt;
	logic [`AUDIO_SAMPLE_W-1:0] dutyNext;
	logic [`AUDIO_SAMPLE_W-1:0] dutyReg;

	// --------------------------------------------------
	// Frame counter
	// --------------------------------------------------
	// Frozen while playback is off
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			frameCnt <= '0;
		else if (audioCke)
			frameCnt <= (frameCnt == CntLast) ? '0 : frameCnt + 1'b1;
	end

	// Last clock of the frame
	assign frameSync = audioCke && (frameCnt == CntLast);

	// --------------------------------------------------
	// Duty source and latch
	// --------------------------------------------------
	always_comb
	begin
		case (audioMode)
			audioPkg::MODE_TONE:
				dutyNext = toneSample;
			audioPkg::MODE_PCM:
				dutyNext = pcmSample;
			default:
				dutyNext = audioDuty;
		endcase
	end

	// Duty for the next frame, fixed for a whole frame
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			dutyReg <= '0;
		else if (frameSync)
			dutyReg <= dutyNext;
	end

	// High for the first dutyReg clocks of the frame
	assign audioPwm = audioCke && (frameCnt < dutyReg);

endmodule

`default_nettype wire

// ==== hw/sampleMemArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module sampleMemArbiter
(
	input  logic              audioClk,
	input  logic              rstN,
	input  audioPkg::memReq_t hostWr,
	input  audioPkg::memReq_t dmaReq,
	output logic              dmaGnt,
	output audioPkg::memRsp_t dmaRsp
);

	localparam int Depth = 1 << `AUDIO_MEM_AW;

	audioPkg::memReq_t          hostBuf;
	audioPkg::memReq_t          hostSel;
	logic                       hostPend;
	logic                       hostWant;
	logic                       hostGnt;
	logic                       hostLoad;
	logic                       lastDma;
	logic [`AUDIO_MEM_AW-1:0]   memAdrs;
	logic [`AUDIO_SAMPLE_W-1:0] rdData;
	logic                       rspValid;
	logic [`AUDIO_SAMPLE_W-1:0] sampleMem [Depth];

	// --------------------------------------------------
	// Host write buffer
	// --------------------------------------------------
	// Buffered write goes first, a fresh one can bypass
	assign hostSel  = hostPend ? hostBuf : hostWr;
	assign hostWant = hostPend || hostWr.valid;
	// Park the new write when it cannot go straight in
	assign hostLoad = hostWr.valid && (hostPend ? hostGnt : !hostGnt);

	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			hostPend <= 1'b0;
		else if (hostLoad)
			hostPend <= 1'b1;
		else if (hostGnt)
			hostPend <= 1'b0;
	end

	always_ff @(posedge audioClk)
	begin
		if (hostLoad)
			hostBuf <= hostWr;
	end

	// --------------------------------------------------
	// Round robin
	// --------------------------------------------------
	// On a tie the side not served last wins
	assign hostGnt = hostWant && (!dmaReq.valid || lastDma);
	assign dmaGnt  = dmaReq.valid && !hostGnt;

	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			lastDma <= 1'b0;
		else if (hostGnt)
			lastDma <= 1'b0;
		else if (dmaGnt)
			lastDma <= 1'b1;
	end

	// --------------------------------------------------
	// Single port memory
	// --------------------------------------------------
	assign memAdrs = hostGnt ? hostSel.adrs : dmaReq.adrs;

	always_ff @(posedge audioClk)
	begin
		if (hostGnt)
			sampleMem[memAdrs] <= hostSel.data;
		else
			rdData <= sampleMem[memAdrs];
	end

	// Response follows the grant by one clock
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			rspValid <= 1'b0;
		else
			rspValid <= dmaGnt;
	end

	assign dmaRsp = '{valid: rspValid, data: rdData};

	// DMA side only ever reads
	dmaGrantIsRead : assert property (@(posedge audioClk) disable iff (!rstN)
		dmaGnt |-> (dmaReq.valid && !dmaReq.write))
		else $error("DMA grant without a read request");

	// A blocked DMA read is served on the next clock
	dmaWaitBounded : assert property (@(posedge audioClk) disable iff (!rstN)
		(dmaReq.valid && !dmaGnt) |=> dmaGnt)
		else $error("DMA read waited more than one cycle");

	// Full buffer with another write means a lost write
	hostNoOverrun : assert property (@(posedge audioClk) disable iff (!rstN)
		(hostWr.valid && hostPend) |-> hostGnt)
		else $error("host write overrun");

endmodule

`default_nettype wire

// ==== hw/toneStepper.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module toneStepper
(
	input  logic                       audioClk,
	input  logic                       rstN,
	input  logic                       frameSync,
	input  logic [6:0]                 audioTone,
	output logic [`AUDIO_SAMPLE_W-1:0] waveIndex
);

	localparam int PhaseW = `AUDIO_PHASE_W;
	localparam int IndexW = `AUDIO_SAMPLE_W;
	localparam logic [6:0] ToneMax = 7'(`AUDIO_TONE_MAX);

	logic [6:0]        toneClamped;
	logic [3:0]        noteSel;
	logic [2:0]        octaveSel;
	logic [PhaseW-1:0] phaseStep;
	logic [PhaseW-1:0] phaseAcc;

	// --------------------------------------------------
	// Tone to phase step
	// --------------------------------------------------
	always_comb
	begin
		// Out of range tones play the top tone
		toneClamped = (audioTone > ToneMax) ? ToneMax : audioTone;
		// Note within the octave, then octave number
		noteSel     = 4'(toneClamped % 7'd12);
		octaveSel   = 3'(toneClamped / 7'd12);
		// Each octave doubles the step
		phaseStep   = audioPkg::NOTE_STEP[noteSel] << octaveSel;
	end

	// --------------------------------------------------
	// Phase accumulator
	// --------------------------------------------------
	// One step per PWM frame, wraps freely
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			phaseAcc <= '0;
		else if (frameSync)
			phaseAcc <= phaseAcc + phaseStep;
	end

	// Integer part of the phase picks the table entry
	assign waveIndex = phaseAcc[PhaseW-1 -: IndexW];

	// Index only moves right after a frame boundary
	indexMovesOnFrame : assert property (@(posedge audioClk) disable iff (!rstN)
		$changed(waveIndex) |-> $past(frameSync))
		else $error("waveIndex changed outside a frame boundary");

endmodule

`default_nettype wire

// ==== hw/waveTableRom.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module waveTableRom
(
	input  logic                       audioClk,
	input  logic [`AUDIO_SAMPLE_W-1:0] waveIndex,
	output logic [`AUDIO_SAMPLE_W-1:0] toneSample
);

	localparam int  Depth   = 1 << `AUDIO_SAMPLE_W;
	localparam int  CodeMax = Depth - 1;
	localparam real Mid     = CodeMax / 2.0;
	localparam real TwoPi   = 6.283185307179586;

	logic [`AUDIO_SAMPLE_W-1:0] sineRom [Depth];

	// One full sine period, centred on mid scale
	initial
	begin
		real angle;
		real level;
		int  code;
		for (int i = 0; i < Depth; i++)
		begin
			angle = TwoPi * i / Depth;
			level = Mid + Mid * $sin(angle);
			// Round to nearest, level is never negative
			code  = $rtoi(level + 0.5);
			if (code > CodeMax)
				code = CodeMax;
			if (code < 0)
				code = 0;
			sineRom[i] = `AUDIO_SAMPLE_W'(code);
		end
	end

	// Registered read, one clock latency
	always_ff @(posedge audioClk)
	begin
		toneSample <= sineRom[waveIndex];
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/audioPkg.sv
hw/toneStepper.sv
hw/waveTableRom.sv
hw/pcmDmaReader.sv
hw/sampleMemArbiter.sv
hw/pwmDutyGen.sv
hw/audioTxUnit.sv
testbench/tbAudioTxUnit.sv

// ==== testbench/tbAudioTxUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "audio_defs.svh"

module tbAudioTxUnit;

	localparam int ClkPeriod = 4;
	localparam int ToneCount = 6;
	// Frames spent by each test in turn
	localparam int PlannedFrames = 2 + 40 + ToneCount * 8 + 26 + 7;
	// Planned run time plus a fifth
	localparam int TimeoutNs = PlannedFrames * `AUDIO_FRAME_LEN * ClkPeriod * 12 / 10;

	logic                       audioClk;
	logic                       rstN;
	logic                       audioCke;
	audioPkg::audioMode_t       audioMode;
	logic [6:0]                 audioTone;
	logic [`AUDIO_SAMPLE_W-1:0] audioDuty;
	audioPkg::memReq_t          hostWr;
	logic [`AUDIO_MEM_AW-1:0]   dmaAdrs;
	logic [`AUDIO_MEM_AW-1:0]   dmaLen;
	logic                       dmaEn;
	logic                       audioPwm;
	logic                       frameSync;
	logic                       dmaBusy;

	// --------------------------------------------------
	// Reference model state
	// --------------------------------------------------
	int                         highCount;
	int                         curDuty;
	int                         lastMeasured;
	int                         frameCount = 0;
	logic [`AUDIO_PHASE_W-1:0]  modelPhase;
	logic [`AUDIO_SAMPLE_W-1:0] modelPcm;
	logic [`AUDIO_MEM_AW-1:0]   modelPtr;
	int                         modelRemain;
	logic                       prevEn;
	// Mirror of every host write
	logic [`AUDIO_SAMPLE_W-1:0] shadowMem [1 << `AUDIO_MEM_AW];

	int errCount = 0;
	int passCount = 0;
	int failCount = 0;

	audioTxUnit audioTxUnit_inst
	(
		.audioClk  (audioClk),
		.rstN      (rstN),
		.audioCke  (audioCke),
		.audioMode (audioMode),
		.audioTone (audioTone),
		.audioDuty (audioDuty),
		.hostWr    (hostWr),
		.dmaAdrs   (dmaAdrs),
		.dmaLen    (dmaLen),
		.dmaEn     (dmaEn),
		.audioPwm  (audioPwm),
		.frameSync (frameSync),
		.dmaBusy   (dmaBusy)
	);

	initial
	begin
		audioClk = 1'b0;
		forever #(ClkPeriod / 2) audioClk = ~audioClk;
	end

	// Note step shifted up by the octave of the clamped tone
	function automatic logic [`AUDIO_PHASE_W-1:0] toneStep(input int tone);
		int t;
		t = (tone > `AUDIO_TONE_MAX) ? `AUDIO_TONE_MAX : tone;
		return audioPkg::NOTE_STEP[t % 12] << (t / 12);
	endfunction

	// Rounded and limited sine level around mid scale
	function automatic int sineLevel(input int idx);
		real level;
		int  code;
		level = 127.5 + 127.5 * $sin(6.283185307179586 * idx / 256);
		code  = $rtoi(level + 0.5);
		if (code > 255)
			code = 255;
		if (code < 0)
			code = 0;
		return code;
	endfunction

	// --------------------------------------------------
	// Duty measurement and model
	// --------------------------------------------------
	always @(posedge audioClk)
	begin
		if (!rstN)
		begin
			highCount   = 0;
			curDuty     = 0;
			modelPhase  = '0;
			modelPcm    = '0;
			modelRemain = 0;
			prevEn      = 1'b0;
		end
		else
		begin
			// Paused playback stays silent
			if (!audioCke && (frameSync || audioPwm))
			begin
				$display("frameSync or audioPwm went high while audioCke was low at %0t", $time);
				errCount++;
			end
			if (audioPwm)
				highCount++;
			if (frameSync)
			begin
				if (highCount != curDuty)
				begin
					$display("error %0t audioPwm duty expected %0d measured %0d",
						$time, curDuty, highCount);
					errCount++;
				end
				if (dmaBusy !== (modelRemain != 0))
				begin
					$display("error %0t dmaBusy expected %0b measured %0b",
						$time, (modelRemain != 0), dmaBusy);
					errCount++;
				end
				lastMeasured = highCount;
				highCount    = 0;
				// Source value now plays in the next frame
				case (audioMode)
					audioPkg::MODE_TONE:
						curDuty = sineLevel(modelPhase[`AUDIO_PHASE_W-1 -: `AUDIO_SAMPLE_W]);
					audioPkg::MODE_PCM:
						curDuty = modelPcm;
					default:
						curDuty = audioDuty;
				endcase
				modelPhase = modelPhase + toneStep(audioTone);
				// One fetch per frame lands before the next latch
				if (modelRemain != 0)
				begin
					modelPcm    = shadowMem[modelPtr];
					modelPtr    = modelPtr + 1'b1;
					modelRemain = modelRemain - 1;
				end
				frameCount++;
			end
			if (dmaEn && !prevEn)
			begin
				modelPtr    = dmaAdrs;
				modelRemain = dmaLen;
			end
			prevEn = dmaEn;
			if (hostWr.valid && hostWr.write)
				shadowMem[hostWr.adrs] = hostWr.data;
		end
	end

	task automatic waitFrames(input int n);
		int target;
		target = frameCount + n;
		wait (frameCount >= target);
	endtask

	// Single write strobe followed by idle clocks
	task automatic hostWrite(input int adrs, input int data);
		@(negedge audioClk);
		hostWr = '{valid: 1'b1, write: 1'b1, adrs: `AUDIO_MEM_AW'(adrs),
			data: `AUDIO_SAMPLE_W'(data)};
		@(negedge audioClk);
		hostWr = '0;
		@(negedge audioClk);
	endtask

	task automatic reportTest(input string name, input int errStart);
		if (errCount == errStart)
		begin
			passCount++;
			$display("%s test passed", name);
		end
		else
		begin
			failCount++;
			$display("%s test failed with %0d errors", name, errCount - errStart);
		end
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	initial
	begin
		int seedInit;
		int errStart;
		int duty;
		int tone;
		int base;
		int len;
		int adrs;
		int frameMark;
		audioCke  = 1'b0;
		audioMode = audioPkg::MODE_DIRECT;
		audioTone = '0;
		audioDuty = '0;
		hostWr    = '0;
		dmaAdrs   = '0;
		dmaLen    = '0;
		dmaEn     = 1'b0;
		rstN      = 1'b0;
		seedInit  = $urandom(11);

		// Reset followed by one empty frame
		errStart = errCount;
		repeat (9) @(posedge audioClk);
		// Playback on while reset still holds the counter and duty
		@(negedge audioClk);
		audioCke = 1'b1;
		@(negedge audioClk);
		if (audioPwm !== 1'b0)
		begin
			$display("error %0t audioPwm expected 0 measured %b", $time, audioPwm);
			errCount++;
		end
		if (frameSync !== 1'b0)
		begin
			$display("error %0t frameSync expected 0 measured %b", $time, frameSync);
			errCount++;
		end
		if (dmaBusy !== 1'b0)
		begin
			$display("error %0t dmaBusy expected 0 measured %b", $time, dmaBusy);
			errCount++;
		end
		rstN = 1'b1;
		waitFrames(1);
		if (lastMeasured != 0)
		begin
			$display("error %0t audioPwm duty expected 0 measured %0d", $time, lastMeasured);
			errCount++;
		end
		reportTest("reset", errStart);

		// Second frame of each pair plays the direct duty
		errStart = errCount;
		for (int i = 0; i < 20; i++)
		begin
			duty = (i == 3) ? 0 : $urandom % 256;
			@(negedge audioClk);
			audioDuty = duty;
			waitFrames(2);
			if (lastMeasured != duty)
			begin
				$display("error %0t audioPwm duty expected %0d measured %0d",
					$time, duty, lastMeasured);
				errCount++;
			end
		end
		reportTest("direct", errStart);

		// First tone lies above the legal range
		errStart = errCount;
		@(negedge audioClk);
		audioMode = audioPkg::MODE_TONE;
		for (int i = 0; i < ToneCount; i++)
		begin
			tone = (i == 0) ? 96 + $urandom % 32 : $urandom % 128;
			@(negedge audioClk);
			audioTone = tone;
			waitFrames(8);
		end
		reportTest("tone", errStart);

		// PCM window fill followed by DMA with background writes
		errStart = errCount;
		base = $urandom % 1024;
		len  = 5 + $urandom % 16;
		for (int i = 0; i < len; i++)
			hostWrite(base + i, $urandom % 256);
		waitFrames(1);
		@(negedge audioClk);
		audioMode = audioPkg::MODE_PCM;
		dmaAdrs   = base;
		dmaLen    = len;
		dmaEn     = 1'b1;
		for (int i = 0; i < len + 3; i++)
		begin
			repeat (1 + $urandom % 3)
			begin
				// Anywhere outside the playing window
				adrs = base + len + $urandom % (1024 - len);
				hostWrite(adrs, $urandom % 256);
			end
			waitFrames(1);
		end
		// Last sample keeps playing
		if (lastMeasured != shadowMem[(base + len - 1) % 1024])
		begin
			$display("error %0t audioPwm duty expected %0d measured %0d",
				$time, shadowMem[(base + len - 1) % 1024], lastMeasured);
			errCount++;
		end
		@(negedge audioClk);
		if (dmaBusy !== 1'b0)
		begin
			$display("error %0t dmaBusy expected 0 measured %b", $time, dmaBusy);
			errCount++;
		end
		dmaEn = 1'b0;
		reportTest("pcm", errStart);

		// Duty latched before a mid frame pause stays
		errStart = errCount;
		@(negedge audioClk);
		audioMode = audioPkg::MODE_DIRECT;
		duty      = 1 + $urandom % 255;
		audioDuty = duty;
		waitFrames(2);
		repeat (10 + $urandom % 200) @(negedge audioClk);
		frameMark = frameCount;
		audioCke  = 1'b0;
		audioDuty = duty ^ 8'hFF;
		repeat (16 + $urandom % 300) @(negedge audioClk);
		if (frameCount != frameMark)
		begin
			$display("frame ended while audioCke was low at %0t", $time);
			errCount++;
		end
		audioCke = 1'b1;
		waitFrames(1);
		if (lastMeasured != duty)
		begin
			$display("error %0t audioPwm duty expected %0d measured %0d",
				$time, duty, lastMeasured);
			errCount++;
		end
		waitFrames(1);
		if (lastMeasured != (duty ^ 8'hFF))
		begin
			$display("error %0t audioPwm duty expected %0d measured %0d",
				$time, duty ^ 8'hFF, lastMeasured);
			errCount++;
		end
		reportTest("gating", errStart);

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TimeoutNs);
		$display("run timed out at %0t before all frames were played", $time);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
